// File: rtl/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU      = 2'd0,
        WB_LOAD     = 2'd1,
        WB_PC_PLUS4 = 2'd2
    } wb_sel_e;

    // instruction formats, msb first
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

    typedef struct packed {
        alu_op_e    alu_op;
        logic       src_a_pc;   // operand a is the pc
        logic       src_b_imm;  // operand b is the immediate
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic       mem_read;
        logic       mem_write;
        logic [2:0] funct3;
        logic       reg_write;
        wb_sel_e    wb_sel;
        logic       csr_write;
        logic       csr_imm;    // csrrwi, value is the rs1 field
    } ctrl_t;

    typedef struct packed {
        xlen_t     pc;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        xlen_t     rs1_data;
        xlen_t     rs2_data;
        xlen_t     imm;
        ctrl_t     ctrl;
        logic      valid;
    } id_ex_t;

    typedef struct packed {
        xlen_t      alu_result;
        xlen_t      pc_plus4;
        reg_addr_t  rd;
        logic [2:0] funct3;
        wb_sel_e    wb_sel;
        logic [1:0] byte_off;
        logic       reg_write;
    } ex_wb_t;

    localparam logic [11:0] CSR_TOHOST_ADDR = 12'h51e;
    localparam xlen_t       NOP_INST        = 32'h0000_0013; // addi x0, x0, 0

endpackage

`default_nettype wire

// File: rtl/rv_sync_ram.sv
`timescale 1ns/1ps
`default_nettype none

module rv_sync_ram import rv_core_pkg::*; #(
    parameter int DEPTH = 1024
) (
    input  logic       clk,
    input  xlen_t      addr_i,   // word index
    input  xlen_t      wdata_i,
    input  logic [3:0] be_i,
    output xlen_t      rdata_o
);

    localparam int AW = $clog2(DEPTH);

    xlen_t mem [DEPTH];

    always @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (be_i[b]) begin
                mem[addr_i[AW-1:0]][8*b +: 8] <= wdata_i[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        rdata_o <= mem[addr_i[AW-1:0]]; // old data on a same-cycle write
    end

    // upper address bits are dropped above, so an out-of-range index would alias
    a_addr_in_range: assert property (@(posedge clk) addr_i < DEPTH);

endmodule

`default_nettype wire

// File: rtl/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  reg_addr_t ra1_i,
    input  reg_addr_t ra2_i,
    output xlen_t     rd1_o,
    output xlen_t     rd2_o,
    input  logic      we_i,
    input  reg_addr_t wa_i,
    input  xlen_t     wd_i
);

    xlen_t regs [32];

    always_ff @(posedge clk) begin
        if (we_i && wa_i != '0) begin
            regs[wa_i] <= wd_i;
        end
    end

    // x0 reads as zero ahead of the write-through bypass
    assign rd1_o = (ra1_i == '0) ? '0 : (we_i && wa_i == ra1_i) ? wd_i : regs[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 : (we_i && wa_i == ra2_i) ? wd_i : regs[ra2_i];

    // write-back masks rd == x0 before it gets here
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        we_i |-> wa_i != '0);

endmodule

`default_nettype wire

// File: rtl/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch import rv_core_pkg::*; #(
    parameter xlen_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  redirect_i,
    input  xlen_t target_i,
    output xlen_t imem_addr_o,
    output xlen_t pc_o
);

    xlen_t pc_q;
    xlen_t next_pc;

    // a redirect steers the very next fetch, no extra delay
    assign next_pc     = redirect_i ? target_i : pc_q + 32'd4;
    assign imem_addr_o = next_pc;       // byte address, top slices the word index
    assign pc_o        = pc_q;          // tags the word leaving imem

    // held one word back so the first fetch out of reset reads RESET_PC
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC - 32'd4;
        end else begin
            pc_q <= next_pc;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder import rv_core_pkg::*; (
    input  inst_u     inst_i,
    output ctrl_t     ctrl_o,
    output xlen_t     imm_o,
    output reg_addr_t rs1_o,
    output reg_addr_t rs2_o,
    output reg_addr_t rd_o
);

    xlen_t imm_itype;
    xlen_t imm_stype;
    xlen_t imm_btype;
    xlen_t imm_utype;
    xlen_t imm_jtype;
    logic  csr_hit;

    // bit 30 picks sub/sra, but only r-type uses it for sub
    function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic alt,
                                             input logic reg_op);
        case (f3)
            3'b000:  return (alt && reg_op) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign imm_itype = {{20{inst_i.i.imm[11]}}, inst_i.i.imm};
    assign imm_stype = {{20{inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
    assign imm_btype = {{19{inst_i.b.imm12}}, inst_i.b.imm12, inst_i.b.imm11,
                        inst_i.b.imm10_5, inst_i.b.imm4_1, 1'b0};
    assign imm_utype = {inst_i.u.imm, 12'b0};
    assign imm_jtype = {{11{inst_i.j.imm20}}, inst_i.j.imm20, inst_i.j.imm19_12,
                        inst_i.j.imm11, inst_i.j.imm10_1, 1'b0};

    // csrrw (001) or csrrwi (101) to the tohost register
    assign csr_hit = (inst_i.i.imm == CSR_TOHOST_ADDR) && (inst_i.i.funct3[1:0] == 2'b01);

    assign rs1_o = inst_i.r.rs1;    // uimm for csrrwi
    assign rs2_o = inst_i.r.rs2;
    assign rd_o  = inst_i.r.rd;

    always_comb begin
        ctrl_o        = '0;
        ctrl_o.alu_op = ALU_ADD;
        ctrl_o.wb_sel = WB_ALU;
        ctrl_o.funct3 = inst_i.r.funct3;
        imm_o         = imm_itype;
        case (opcode_e'(inst_i.r.opcode))
            OPC_OP: begin
                ctrl_o.alu_op    = funct_to_alu(inst_i.r.funct3, inst_i.r.funct7[5], 1'b1);
                ctrl_o.reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                ctrl_o.alu_op    = funct_to_alu(inst_i.r.funct3, inst_i.r.funct7[5], 1'b0);
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.reg_write = 1'b1;
            end
            OPC_LOAD: begin
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.mem_read  = 1'b1;
                ctrl_o.reg_write = 1'b1;
                ctrl_o.wb_sel    = WB_LOAD;
            end
            OPC_STORE: begin
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.mem_write = 1'b1;
                imm_o            = imm_stype;
            end
            OPC_BRANCH: begin
                ctrl_o.is_branch = 1'b1;    // alu sees rs1/rs2 for the compare
                imm_o            = imm_btype;
            end
            OPC_JAL: begin
                ctrl_o.is_jal    = 1'b1;
                ctrl_o.reg_write = 1'b1;
                ctrl_o.wb_sel    = WB_PC_PLUS4;
                imm_o            = imm_jtype;
            end
            OPC_JALR: begin
                ctrl_o.is_jalr   = 1'b1;
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.reg_write = 1'b1;
                ctrl_o.wb_sel    = WB_PC_PLUS4;
            end
            OPC_LUI: begin
                ctrl_o.alu_op    = ALU_PASS_B;
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.reg_write = 1'b1;
                imm_o            = imm_utype;
            end
            OPC_AUIPC: begin
                ctrl_o.src_a_pc  = 1'b1;
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.reg_write = 1'b1;
                imm_o            = imm_utype;
            end
            OPC_SYSTEM: begin
                ctrl_o.csr_write = csr_hit; // no rd write, csr reads are not kept
                ctrl_o.csr_imm   = inst_i.i.funct3[2];
            end
            default: ;                      // unknown opcode runs as a no-op
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_core_pkg::*; (
    input  alu_op_e    op_i,
    input  xlen_t      a_i,
    input  xlen_t      b_i,
    input  logic [2:0] funct3_i,
    output xlen_t      result_o,
    output logic       branch_taken_o
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;
    logic       eq;

    assign shamt = b_i[4:0];
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;
    assign eq    = a_i == b_i;

    always_comb begin
        case (op_i)
            ALU_ADD:    result_o = a_i + b_i;
            ALU_SUB:    result_o = a_i - b_i;
            ALU_SLL:    result_o = a_i << shamt;
            ALU_SLT:    result_o = {31'b0, lt_s};
            ALU_SLTU:   result_o = {31'b0, lt_u};
            ALU_XOR:    result_o = a_i ^ b_i;
            ALU_SRL:    result_o = a_i >> shamt;
            ALU_SRA:    result_o = xlen_t'($signed(a_i) >>> shamt);
            ALU_OR:     result_o = a_i | b_i;
            ALU_AND:    result_o = a_i & b_i;
            ALU_PASS_B: result_o = b_i;     // lui
            default:    result_o = '0;
        endcase
    end

    // branch compare, funct3 encodings per rv32i
    always_comb begin
        case (funct3_i)
            3'b000:  branch_taken_o = eq;
            3'b001:  branch_taken_o = !eq;
            3'b100:  branch_taken_o = lt_s;
            3'b101:  branch_taken_o = !lt_s;
            3'b110:  branch_taken_o = lt_u;
            3'b111:  branch_taken_o = !lt_u;
            default: branch_taken_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute import rv_core_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  id_ex_t     id_ex_i,
    input  xlen_t      fwd_data_i,
    output logic       redirect_o,
    output xlen_t      target_o,
    output xlen_t      dmem_addr_o,    // word index
    output xlen_t      dmem_wdata_o,
    output logic [3:0] dmem_be_o,
    output ex_wb_t     ex_wb_o,
    output xlen_t      csr_o,
    output logic       csr_we_o
);

    id_ex_t     id_ex_q;
    id_ex_t     id_ex_d;
    ex_wb_t     ex_wb_d;
    ctrl_t      ctrl;
    xlen_t      rs1_val;
    xlen_t      rs2_val;
    xlen_t      alu_y;
    logic       br_taken;
    logic       fwd_ok;
    logic       run_q;
    logic [3:0] be;

    assign ctrl   = id_ex_q.ctrl;
    assign fwd_ok = ex_wb_o.reg_write && ex_wb_o.rd != '0;

    // write-back is the only forwarding source
    assign rs1_val = (fwd_ok && ex_wb_o.rd == id_ex_q.rs1) ? fwd_data_i : id_ex_q.rs1_data;
    assign rs2_val = (fwd_ok && ex_wb_o.rd == id_ex_q.rs2) ? fwd_data_i : id_ex_q.rs2_data;

    rv_alu u_alu (
        .op_i           (ctrl.alu_op),
        .a_i            (ctrl.src_a_pc ? id_ex_q.pc : rs1_val),
        .b_i            (ctrl.src_b_imm ? id_ex_q.imm : rs2_val),
        .funct3_i       (ctrl.funct3),
        .result_o       (alu_y),
        .branch_taken_o (br_taken)
    );

    assign redirect_o = id_ex_q.valid && (ctrl.is_jal || ctrl.is_jalr ||
                                          (ctrl.is_branch && br_taken));
    assign target_o   = ctrl.is_jalr ? {alu_y[31:1], 1'b0} : id_ex_q.pc + id_ex_q.imm;

    // lanes replicated, byte enables pick the target bytes
    always_comb begin
        dmem_wdata_o = rs2_val;
        be           = 4'b1111;
        case (ctrl.funct3[1:0])
            2'b00: begin
                dmem_wdata_o = {4{rs2_val[7:0]}};
                be           = 4'b0001 << alu_y[1:0];
            end
            2'b01: begin
                dmem_wdata_o = {2{rs2_val[15:0]}};
                be           = alu_y[1] ? 4'b1100 : 4'b0011;
            end
            default: ;
        endcase
    end

    assign dmem_be_o   = (id_ex_q.valid && ctrl.mem_write) ? be : 4'b0000;
    assign dmem_addr_o = (id_ex_q.valid && (ctrl.mem_read || ctrl.mem_write)) ?
                         {2'b00, alu_y[31:2]} : '0;     // idle at word 0

    always_comb begin
        id_ex_d       = id_ex_i;
        id_ex_d.valid = id_ex_i.valid && run_q && !redirect_o;  // squash wrong path

        ex_wb_d.alu_result = alu_y;
        ex_wb_d.pc_plus4   = id_ex_q.pc + 32'd4;
        ex_wb_d.rd         = id_ex_q.rd;
        ex_wb_d.funct3     = ctrl.funct3;
        ex_wb_d.wb_sel     = ctrl.wb_sel;
        ex_wb_d.byte_off   = alu_y[1:0];
        ex_wb_d.reg_write  = ctrl.reg_write && id_ex_q.valid;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run_q    <= 1'b0;   // imem word is stale on the first cycle
            id_ex_q  <= '0;
            ex_wb_o  <= '0;
            csr_o    <= '0;
            csr_we_o <= 1'b0;
        end else begin
            run_q    <= 1'b1;
            id_ex_q  <= id_ex_d;
            ex_wb_o  <= ex_wb_d;
            csr_we_o <= id_ex_q.valid && ctrl.csr_write;
            if (id_ex_q.valid && ctrl.csr_write) begin
                csr_o <= ctrl.csr_imm ? {27'b0, id_ex_q.rs1} : rs1_val;
            end
        end
    end

    // imem is word indexed, a misaligned target would fetch the wrong word
    a_target_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        redirect_o |-> target_o[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: rtl/rv_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module rv_writeback import rv_core_pkg::*; (
    input  ex_wb_t    ex_wb_i,
    input  xlen_t     dmem_rdata_i,
    output logic      rf_we_o,
    output reg_addr_t rf_wa_o,
    output xlen_t     rf_wd_o
);

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    xlen_t       ld_data;

    assign ld_byte = dmem_rdata_i[8*ex_wb_i.byte_off +: 8];
    assign ld_half = ex_wb_i.byte_off[1] ? dmem_rdata_i[31:16] : dmem_rdata_i[15:0];

    always_comb begin
        case (ex_wb_i.funct3)
            3'b000:  ld_data = {{24{ld_byte[7]}}, ld_byte};     // lb
            3'b001:  ld_data = {{16{ld_half[15]}}, ld_half};    // lh
            3'b100:  ld_data = {24'b0, ld_byte};                // lbu
            3'b101:  ld_data = {16'b0, ld_half};                // lhu
            default: ld_data = dmem_rdata_i;                    // lw
        endcase
    end

    always_comb begin
        case (ex_wb_i.wb_sel)
            WB_LOAD:     rf_wd_o = ld_data;
            WB_PC_PLUS4: rf_wd_o = ex_wb_i.pc_plus4;    // link value
            default:     rf_wd_o = ex_wb_i.alu_result;
        endcase
    end

    assign rf_wa_o = ex_wb_i.rd;
    assign rf_we_o = ex_wb_i.reg_write && ex_wb_i.rd != '0;

endmodule

`default_nettype wire

// File: rtl/rv151_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv151_top import rv_core_pkg::*; #(
    parameter xlen_t RESET_PC   = '0,
    parameter int    IMEM_DEPTH = 1024,
    parameter int    DMEM_DEPTH = 1024
) (
    input  logic  clk,
    input  logic  rst_n_i,
    output xlen_t csr_o,
    output logic  csr_we_o
);

    xlen_t      imem_addr;
    xlen_t      pc;
    inst_u      inst;
    ctrl_t      ctrl;
    xlen_t      imm;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    xlen_t      rd1;
    xlen_t      rd2;
    id_ex_t     id_ex;
    logic       redirect;
    xlen_t      target;
    xlen_t      dmem_addr;
    xlen_t      dmem_wdata;
    logic [3:0] dmem_be;
    xlen_t      dmem_rdata;
    ex_wb_t     ex_wb;
    logic       rf_we;
    reg_addr_t  rf_wa;
    xlen_t      rf_wd;

    rv_fetch #(.RESET_PC(RESET_PC)) u_fetch (
        .clk, .rst_n_i,
        .redirect_i (redirect),
        .target_i   (target),
        .imem_addr_o(imem_addr),
        .pc_o       (pc)
    );

    rv_sync_ram #(.DEPTH(IMEM_DEPTH)) u_imem (
        .clk,
        .addr_i (xlen_t'(imem_addr[31:2])),
        .wdata_i('0),
        .be_i   (4'b0000),      // read only
        .rdata_o(inst)
    );

    rv_decoder u_dec (
        .inst_i(inst), .ctrl_o(ctrl), .imm_o(imm),
        .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd)
    );

    rv_regfile u_rf (
        .clk, .rst_n_i,
        .ra1_i(rs1), .ra2_i(rs2), .rd1_o(rd1), .rd2_o(rd2),
        .we_i(rf_we), .wa_i(rf_wa), .wd_i(rf_wd)
    );

    assign id_ex = '{pc: pc, rs1: rs1, rs2: rs2, rd: rd, rs1_data: rd1, rs2_data: rd2,
                     imm: imm, ctrl: ctrl, valid: 1'b1};

    rv_execute u_ex (
        .clk, .rst_n_i,
        .id_ex_i(id_ex), .fwd_data_i(rf_wd),
        .redirect_o(redirect), .target_o(target),
        .dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata), .dmem_be_o(dmem_be),
        .ex_wb_o(ex_wb), .csr_o, .csr_we_o
    );

    rv_sync_ram #(.DEPTH(DMEM_DEPTH)) u_dmem (
        .clk,
        .addr_i(dmem_addr), .wdata_i(dmem_wdata), .be_i(dmem_be), .rdata_o(dmem_rdata)
    );

    rv_writeback u_wb (
        .ex_wb_i(ex_wb), .dmem_rdata_i(dmem_rdata),
        .rf_we_o(rf_we), .rf_wa_o(rf_wa), .rf_wd_o(rf_wd)
    );

endmodule

`default_nettype wire

// File: sim/tb_rv151.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv151 import rv_core_pkg::*; ();

    localparam int NROWS          = 20;
    localparam int ROW_WORDS      = 6;
    localparam int IMEM_WORDS     = 1024;           // top level default depth
    localparam int TIMEOUT_CYCLES = 20 * NROWS + 50;
    localparam int QUIET_CYCLES   = 20;             // no pulse expected once the jal loop runs

    logic  clk;
    logic  rst_n_i;
    xlen_t csr_o;
    logic  csr_we_o;

    xlen_t prog [NROWS][ROW_WORDS];
    xlen_t expect_csr [NROWS];

    rv151_top DUT (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .csr_o    (csr_o),
        .csr_we_o (csr_we_o)
    );

    always #5 clk = ~clk;

    // small assembler for the rv32i formats
    function automatic xlen_t r_word(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_addr_t rd, input reg_addr_t rs1,
                                     input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic xlen_t i_word(input logic [6:0] opc, input logic [2:0] f3,
                                     input reg_addr_t rd, input reg_addr_t rs1,
                                     input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic xlen_t s_word(input logic [2:0] f3, input reg_addr_t rs1,
                                     input reg_addr_t rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic xlen_t b_word(input logic [2:0] f3, input reg_addr_t rs1,
                                     input reg_addr_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic xlen_t u_word(input logic [6:0] opc, input reg_addr_t rd,
                                     input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic xlen_t j_word(input reg_addr_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic xlen_t csr_write_reg(input reg_addr_t rs1);
        return i_word(OPC_SYSTEM, 3'b001, 5'd0, rs1, CSR_TOHOST_ADDR);
    endfunction

    task automatic set_row(input int r, input xlen_t w0, input xlen_t w1, input xlen_t w2,
                           input xlen_t w3, input xlen_t w4, input xlen_t w5,
                           input xlen_t exp);
        prog[r][0]    = w0;
        prog[r][1]    = w1;
        prog[r][2]    = w2;
        prog[r][3]    = w3;
        prog[r][4]    = w4;
        prog[r][5]    = w5;
        expect_csr[r] = exp;
    endtask

    // row r sits at byte address 24*r, expected values worked out by hand
    task automatic build_table();
        xlen_t nop;
        nop = NOP_INST;
        set_row(0, i_word(OPC_OP_IMM, 3'b000, 1, 0, 12'hffb), i_word(OPC_OP_IMM, 3'b000, 1, 1, 12),
                csr_write_reg(1), nop, nop, nop, 32'h0000_0007);
        set_row(1, i_word(OPC_OP_IMM, 3'b000, 2, 0, 3), i_word(OPC_OP_IMM, 3'b000, 3, 0, 10),
                r_word(7'h20, 3'b000, 4, 2, 3), csr_write_reg(4), nop, nop, 32'hffff_fff9);
        set_row(2, i_word(OPC_OP_IMM, 3'b000, 2, 0, 12'h5a5), i_word(OPC_OP_IMM, 3'b000, 3, 0, 12'h0f0),
                r_word(7'h00, 3'b100, 4, 2, 3), csr_write_reg(4), nop, nop, 32'h0000_0555);
        // slt gives 1, sltu gives 0, their difference is all ones
        set_row(3, i_word(OPC_OP_IMM, 3'b000, 2, 0, 12'hfff), i_word(OPC_OP_IMM, 3'b000, 3, 0, 1),
                r_word(7'h00, 3'b010, 4, 2, 3), r_word(7'h00, 3'b011, 5, 2, 3),
                r_word(7'h20, 3'b000, 6, 5, 4), csr_write_reg(6), 32'hffff_ffff);
        set_row(4, u_word(OPC_LUI, 2, 20'h80000), i_word(OPC_OP_IMM, 3'b101, 3, 2, 12'h404),
                csr_write_reg(3), nop, nop, nop, 32'hf800_0000);
        set_row(5, u_word(OPC_LUI, 2, 20'h12345), i_word(OPC_OP_IMM, 3'b000, 3, 0, 4),
                r_word(7'h00, 3'b001, 4, 2, 3), csr_write_reg(4), nop, nop, 32'h2345_0000);
        set_row(6, u_word(OPC_AUIPC, 5, 20'h00001), csr_write_reg(5), nop, nop, nop, nop,
                32'h0000_1090);                                 // pc 0x90 plus 0x1000
        // x1 two back comes through the regfile bypass, x2 through forwarding
        set_row(7, i_word(OPC_OP_IMM, 3'b000, 1, 0, 3), i_word(OPC_OP_IMM, 3'b000, 2, 0, 5),
                r_word(7'h00, 3'b000, 3, 1, 2), r_word(7'h00, 3'b000, 3, 3, 1),
                csr_write_reg(3), nop, 32'h0000_000b);
        set_row(8, u_word(OPC_LUI, 1, 20'h11223), i_word(OPC_OP_IMM, 3'b000, 1, 1, 12'h344),
                s_word(3'b010, 0, 1, 12'h100), i_word(OPC_LOAD, 3'b010, 3, 0, 12'h100),
                csr_write_reg(3), nop, 32'h1122_3344);          // load-use into the csr write
        set_row(9, i_word(OPC_OP_IMM, 3'b000, 2, 0, 12'hf80), s_word(3'b001, 0, 2, 12'h102),
                s_word(3'b000, 0, 2, 12'h101), i_word(OPC_LOAD, 3'b010, 3, 0, 12'h100),
                csr_write_reg(3), nop, 32'hff80_8044);
        set_row(10, i_word(OPC_LOAD, 3'b001, 4, 0, 12'h102), i_word(OPC_LOAD, 3'b101, 5, 0, 12'h100),
                r_word(7'h00, 3'b000, 6, 4, 5), csr_write_reg(6), nop, nop, 32'h0000_7fc4);
        set_row(11, i_word(OPC_LOAD, 3'b000, 4, 0, 12'h101), i_word(OPC_LOAD, 3'b100, 5, 0, 12'h100),
                i_word(OPC_LOAD, 3'b100, 6, 0, 12'h103), r_word(7'h00, 3'b000, 7, 4, 5),
                r_word(7'h00, 3'b000, 7, 7, 6), csr_write_reg(7), 32'h0000_00c3);
        // x1 counts skipped-path instructions, x2 = -1 and x3 = 1 carry to rows 13 to 16
        set_row(12, i_word(OPC_OP_IMM, 3'b000, 1, 0, 0), i_word(OPC_OP_IMM, 3'b000, 2, 0, 12'hfff),
                i_word(OPC_OP_IMM, 3'b000, 3, 0, 1), b_word(3'b000, 3, 3, 8),
                i_word(OPC_OP_IMM, 3'b000, 1, 1, 1), csr_write_reg(1), 32'h0);
        set_row(13, b_word(3'b001, 2, 3, 8), i_word(OPC_OP_IMM, 3'b000, 1, 1, 1),
                b_word(3'b100, 2, 3, 8), i_word(OPC_OP_IMM, 3'b000, 1, 1, 1),
                csr_write_reg(1), nop, 32'h0);
        set_row(14, b_word(3'b101, 3, 2, 8), i_word(OPC_OP_IMM, 3'b000, 1, 1, 1),
                b_word(3'b110, 3, 2, 8), i_word(OPC_OP_IMM, 3'b000, 1, 1, 1),
                csr_write_reg(1), nop, 32'h0);
        // bgeu taken, then a not-taken beq that must not skip the decrement
        set_row(15, b_word(3'b111, 2, 3, 8), i_word(OPC_OP_IMM, 3'b000, 1, 1, 1),
                i_word(OPC_OP_IMM, 3'b000, 1, 1, 1), b_word(3'b000, 2, 3, 8),
                i_word(OPC_OP_IMM, 3'b000, 1, 1, 12'hfff), csr_write_reg(1), 32'h0);
        set_row(16, b_word(3'b110, 2, 3, 8), i_word(OPC_OP_IMM, 3'b000, 1, 1, 2),
                b_word(3'b101, 2, 3, 8), i_word(OPC_OP_IMM, 3'b000, 1, 1, 12'hffe),
                csr_write_reg(1), nop, 32'h0);
        set_row(17, j_word(5, 12), i_word(OPC_OP_IMM, 3'b000, 5, 5, 1),
                i_word(OPC_OP_IMM, 3'b000, 5, 5, 1), csr_write_reg(5), nop, nop,
                32'h0000_019c);                                 // link of jal at 0x198
        // jalr to 0x1c1, bit 0 dropped, lands on slot 4
        set_row(18, i_word(OPC_OP_IMM, 3'b000, 7, 0, 12'h1bc), i_word(OPC_JALR, 3'b000, 8, 7, 5),
                i_word(OPC_OP_IMM, 3'b000, 8, 8, 1), i_word(OPC_OP_IMM, 3'b000, 8, 8, 1),
                csr_write_reg(8), nop, 32'h0000_01b8);
        set_row(19, i_word(OPC_SYSTEM, 3'b101, 0, 5'd27, CSR_TOHOST_ADDR), nop, nop, nop, nop, nop,
                32'h0000_001b);
    endtask

    task automatic load_program();
        // filler words are an addi to x0 tagged with their own index
        for (int i = 0; i < IMEM_WORDS; i++) begin
            DUT.u_imem.mem[i] = i_word(OPC_OP_IMM, 3'b000, 5'd0, 5'd0, i[11:0]);
        end
        for (int r = 0; r < NROWS; r++) begin
            for (int k = 0; k < ROW_WORDS; k++) begin
                DUT.u_imem.mem[r*ROW_WORDS + k] = prog[r][k];
            end
        end
        DUT.u_imem.mem[NROWS*ROW_WORDS] = j_word(0, 0);     // park on a jump to itself
    endtask

    task automatic check_csr(input xlen_t got, input xlen_t exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s csr_o = %h, expected %h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "csr value mismatch");
        end
    endtask

    task automatic verify_strobe(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s csr_we_o = %b, expected %b", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "csr strobe mismatch");
        end
    endtask

    initial begin
        int cycles;
        int pulses;
        clk     = 1'b0;
        rst_n_i = 1'b0;
        cycles  = 0;
        pulses  = 0;
        build_table();
        load_program();
        repeat (10) begin
            @(negedge clk);
            verify_strobe(csr_we_o, 1'b0, "during reset");
            check_csr(csr_o, '0, "during reset");
        end
        rst_n_i = 1'b1;

        // one pulse per row, sampled away from the rising edge
        while (pulses < NROWS && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (csr_we_o === 1'b1) begin
                check_csr(csr_o, expect_csr[pulses], $sformatf("row %0d", pulses));
                pulses++;
            end
        end

        if (pulses == NROWS) begin
            repeat (QUIET_CYCLES) begin
                @(negedge clk);
                verify_strobe(csr_we_o, 1'b0, "after the last row");
            end
        end

        if (pulses != NROWS) begin
            $display("timeout: only %0d of %0d csr writes seen after %0d cycles",
                     pulses, NROWS, cycles);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tb.f
rtl/rv_core_pkg.sv
rtl/rv_sync_ram.sv
rtl/rv_regfile.sv
rtl/rv_fetch.sv
rtl/rv_decoder.sv
rtl/rv_alu.sv
rtl/rv_execute.sv
rtl/rv_writeback.sv
rtl/rv151_top.sv
sim/tb_rv151.sv
